//--- Makefile
# Verilator simulation of the UART receiver

VERILATOR ?= verilator
TOP       ?= tb_uart_rx
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, output in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- baud_timer.sv
// Bit period timer
`timescale 1ns/1ps

module baud_timer (
    input  logic CLK_100MHz,
    input  logic rst_n,
    input  logic clear,
    input  logic timer_load,
    input  logic timer_half,
    output logic timer_done
);
    import uart_rx_pkg::*;

    timer_t cnt;
    logic   running;

    // Count N-1 down to zero so that done comes exactly N cycles after the load
    localparam timer_t LOAD_HALF = timer_t'(HALF_PERIOD - 1);
    localparam timer_t LOAD_FULL = timer_t'(BIT_PERIOD - 1);

    always_ff @(posedge CLK_100MHz) begin
        if (!rst_n || clear) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (timer_load) begin       // Reload wins over expiry
            cnt     <= timer_half ? LOAD_HALF : LOAD_FULL;
            running <= 1'b1;
        end else if (running) begin
            if (cnt == '0) begin
                running <= 1'b0;             // Stop after the done pulse
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // One cycle pulse at expiry
    assign timer_done = running && (cnt == '0);

endmodule

//--- rx_fifo.sv
// Receive word buffer with credit flow control
`timescale 1ns/1ps

module rx_fifo (
    input  logic                  CLK_100MHz,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  word_push,
    input  uart_rx_pkg::rx_word_t rx_word,
    input  logic                  credit_return,
    output uart_rx_pkg::rx_word_t word,
    output logic                  word_valid,
    output logic                  overflow
);
    import uart_rx_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    rx_word_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                // 0 to FIFO_DEPTH
    credit_t          credits;

    logic empty;
    logic full;
    logic wr_en;
    logic rd_en;

    assign empty = (count == '0);
    assign full  = (count == FIFO_DEPTH[PTR_W:0]);
    assign wr_en = word_push && !full;      // Word dropped when full

    // Deliver only with a word waiting and a credit in hand
    assign rd_en      = !empty && (credits != '0);
    assign word_valid = rd_en;
    assign word       = mem[rd_ptr];

    // Storage, no reset
    always_ff @(posedge CLK_100MHz) begin
        if (wr_en) begin
            mem[wr_ptr] <= rx_word;
        end
    end

    always_ff @(posedge CLK_100MHz) begin
        if (!rst_n || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps, depth is a power of two
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Credit counter
    always_ff @(posedge CLK_100MHz) begin
        if (!rst_n || clear) begin
            credits <= credit_t'(CREDIT_INIT);
        end else begin
            case ({word_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // Both or neither
            endcase
        end
    end

    // Sticky until reset or clear
    always_ff @(posedge CLK_100MHz) begin
        if (!rst_n || clear) begin
            overflow <= 1'b0;
        end else if (word_push && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

//--- rx_fsm.sv
// UART frame state machine
`timescale 1ns/1ps

module rx_fsm (
    input  logic CLK_100MHz,
    input  logic rst_n,
    input  logic clear,
    input  logic rx_bit,
    input  logic timer_done,
    output logic timer_load,
    output logic timer_half,
    output logic shift_en,
    output logic word_push,
    output logic frame_err
);
    import uart_rx_pkg::*;

    rx_state_t  state;
    rx_state_t  state_nxt;
    logic [2:0] bit_idx;
    logic [2:0] bit_idx_nxt;
    logic       rx_prev;                    // Previous line level for edge detect
    logic       start_edge;

    assign start_edge = rx_prev && !rx_bit;

    always_ff @(posedge CLK_100MHz) begin
        if (!rst_n || clear) begin
            state   <= ST_IDLE;
            bit_idx <= '0;
            rx_prev <= 1'b1;                // Idle line is high
        end else begin
            state   <= state_nxt;
            bit_idx <= bit_idx_nxt;
            rx_prev <= rx_bit;
        end
    end

    always_comb begin
        state_nxt   = state;
        bit_idx_nxt = bit_idx;
        timer_load  = 1'b0;
        timer_half  = 1'b0;
        shift_en    = 1'b0;
        word_push   = 1'b0;

        case (state)
            ST_IDLE: begin
                if (start_edge) begin
                    timer_load = 1'b1;
                    timer_half = 1'b1;      // Wait to mid start bit
                    state_nxt  = ST_START;
                end
            end

            ST_START: begin
                if (timer_done) begin
                    if (!rx_bit) begin      // Start bit still low
                        timer_load  = 1'b1;
                        bit_idx_nxt = '0;
                        state_nxt   = ST_DATA;
                    end else begin
                        state_nxt = ST_IDLE;  // Glitch, no word
                    end
                end
            end

            ST_DATA: begin
                if (timer_done) begin
                    shift_en   = 1'b1;
                    timer_load = 1'b1;
                    if (bit_idx == 3'd7) begin
                        state_nxt = ST_STOP;
                    end else begin
                        bit_idx_nxt = bit_idx + 1'b1;
                    end
                end
            end

            ST_STOP: begin
                if (timer_done) begin
                    word_push = 1'b1;       // Delivered even with a bad stop bit
                    state_nxt = ST_IDLE;
                end
            end

            default: state_nxt = ST_IDLE;
        endcase
    end

    // Low stop bit means a framing error, qualified by word_push
    assign frame_err = (state == ST_STOP) && !rx_bit;

endmodule

//--- rx_shift.sv
// Receive synchronizer and shift register
`timescale 1ns/1ps

module rx_shift (
    input  logic                  CLK_100MHz,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  rx,
    input  logic                  shift_en,
    input  logic                  frame_err,
    output logic                  rx_bit,
    output uart_rx_pkg::rx_word_t rx_word
);
    import uart_rx_pkg::*;

    logic [1:0] rx_sync;                    // Two flop synchronizer
    rx_byte_t   data_sr;

    always_ff @(posedge CLK_100MHz) begin
        if (!rst_n || clear) begin
            rx_sync <= 2'b11;               // Line idles high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    assign rx_bit = rx_sync[1];

    // Data arrives LSB first, so shift in from the top
    always_ff @(posedge CLK_100MHz) begin
        if (!rst_n || clear) begin
            data_sr <= '0;
        end else if (shift_en) begin
            data_sr <= {rx_bit, data_sr[7:1]};
        end
    end

    // Framing error in bit 15, data in the low byte
    assign rx_word = {frame_err, 7'b0, data_sr};

endmodule

//--- tb_uart_rx.sv
// UART receiver testbench
`timescale 1ns/1ps

module tb_uart_rx;
    import uart_rx_pkg::*;

    localparam int NUM_FRAMES = 53;              // All frames sent below
    localparam int MAX_CYCLES = NUM_FRAMES * 12 * BIT_PERIOD + 20_000;

    logic     CLK_100MHz;
    logic     rst_n;
    logic     clear;
    logic     rx;
    logic     credit_return;
    rx_word_t word;
    logic     word_valid;
    logic     overflow;

    rx_word_t exp_q[$];                          // Words still to arrive
    int       errors;
    int       rx_count;                          // Words seen by the consumer
    int       owed;                              // Credits spent, not yet returned
    bit       hold_credits;
    int       cycles;
    int       base;

    uart_rx_top i_uart_rx_top (
        .CLK_100MHz    (CLK_100MHz),
        .rst_n         (rst_n),
        .clear         (clear),
        .rx            (rx),
        .credit_return (credit_return),
        .word          (word),
        .word_valid    (word_valid),
        .overflow      (overflow)
    );

    always #5 CLK_100MHz = ~CLK_100MHz;

    // Expected receive word from a byte and its stop bit level
    function automatic rx_word_t expected_word(input rx_byte_t data, input logic stop_bit);
        rx_word_t w;
        w      = '0;
        w[7:0] = data;
        w[15]  = !stop_bit;                      // Low stop bit is a framing error
        return w;
    endfunction

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_bit(input logic level);
        rx <= level;
        repeat (BIT_PERIOD) @(posedge CLK_100MHz);
    endtask

    // Start bit, data LSB first, stop bit, one idle bit
    task automatic send_frame(input rx_byte_t data, input logic stop_bit, input bit tracked);
        rx_byte_t sr;
        sr = data;
        if (tracked) begin
            exp_q.push_back(expected_word(data, stop_bit));
        end
        drive_bit(1'b0);
        repeat (8) begin
            drive_bit(sr[0]);
            sr = sr >> 1;
        end
        drive_bit(stop_bit);
        drive_bit(1'b1);
    endtask

    task automatic set_hold(input bit value);
        @(negedge CLK_100MHz);
        hold_credits = value;
        @(posedge CLK_100MHz);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || owed != 0) begin
            @(posedge CLK_100MHz);
        end
    endtask

    // Consumer side, samples in mid cycle
    initial begin : consumer
        rx_word_t exp_w;
        forever begin
            @(negedge CLK_100MHz);
            if (rst_n && word_valid) begin
                rx_count = rx_count + 1;
                owed     = owed + 1;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%0t ns: word %h arrived with no frame outstanding", $time, word);
                end else begin
                    exp_w = exp_q.pop_front();
                    check_value(word, exp_w, "received word");
                end
            end
        end
    end

    initial begin : credit_returner
        int delay;
        forever begin
            @(posedge CLK_100MHz);
            if (owed > 0 && !hold_credits) begin
                delay = $urandom_range(0, 15);
                repeat (delay) @(posedge CLK_100MHz);
                credit_return <= 1'b1;
                @(negedge CLK_100MHz);
                owed = owed - 1;
                @(posedge CLK_100MHz);
                credit_return <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge CLK_100MHz);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        CLK_100MHz    = 1'b0;
        rst_n         = 1'b0;
        clear         = 1'b0;
        rx            = 1'b1;
        credit_return = 1'b0;
        errors        = 0;
        rx_count      = 0;
        owed          = 0;
        hold_credits  = 1'b0;
        void'($urandom(55));
        repeat (10) @(posedge CLK_100MHz);
        rst_n <= 1'b1;
        repeat (5) @(posedge CLK_100MHz);

        repeat (20) begin
            send_frame(rx_byte_t'($urandom), 1'b1, 1'b1);
        end
        send_frame(8'hA5, 1'b0, 1'b1);           // Framing error keeps the data
        wait_drained();

        // Short start pulse
        base = rx_count;
        rx <= 1'b0;
        repeat (HALF_PERIOD / 4) @(posedge CLK_100MHz);
        rx <= 1'b1;
        repeat (12 * BIT_PERIOD) @(posedge CLK_100MHz);  // Longer than a whole frame
        check_value(16'(rx_count - base), 16'd0, "words after a false start");
        send_frame(8'h3C, 1'b1, 1'b1);
        wait_drained();

        // Credits held until the buffer is full
        set_hold(1'b1);
        base = rx_count;
        repeat (FIFO_DEPTH + CREDIT_INIT) begin
            send_frame(rx_byte_t'($urandom), 1'b1, 1'b1);
        end
        check_value(16'(rx_count - base), 16'(CREDIT_INIT), "words without credit return");
        check_value({15'b0, overflow}, 16'd0, "overflow at full buffer");
        set_hold(1'b0);
        wait_drained();

        // Two frames beyond a full buffer
        set_hold(1'b1);
        repeat (FIFO_DEPTH + CREDIT_INIT) begin
            send_frame(rx_byte_t'($urandom), 1'b1, 1'b1);
        end
        repeat (2) begin
            send_frame(rx_byte_t'($urandom), 1'b1, 1'b0);
        end
        @(negedge CLK_100MHz);
        check_value({15'b0, overflow}, 16'd1, "overflow after lost words");
        @(posedge CLK_100MHz);
        clear <= 1'b1;
        @(posedge CLK_100MHz);
        clear <= 1'b0;
        @(negedge CLK_100MHz);
        exp_q.delete();                          // Buffer flushed by clear
        owed = 0;
        check_value({15'b0, overflow}, 16'd0, "overflow after clear");
        check_value({15'b0, word_valid}, 16'd0, "word_valid after clear");
        @(posedge CLK_100MHz);

        // Full credit grant again after clear
        base = rx_count;
        repeat (CREDIT_INIT + 1) begin
            send_frame(rx_byte_t'($urandom), 1'b1, 1'b1);
        end
        check_value(16'(rx_count - base), 16'(CREDIT_INIT), "words after clear");
        set_hold(1'b0);
        wait_drained();
        repeat (20) @(posedge CLK_100MHz);

        $display("Errors: %0d, words received: %0d", errors, rx_count);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- uart_rx_asserts.sv
// Buffer and credit assertions
`timescale 1ns/1ps

module uart_rx_asserts (
    input logic                 CLK_100MHz,
    input logic                 rst_n,
    input logic                 clear,
    input logic                 word_push,
    input logic                 credit_return,
    input uart_rx_pkg::credit_t credits,
    input logic                 word_valid,
    input logic                 overflow
);
    import uart_rx_pkg::*;

    // Buffer fill and credits as the flow control rules predict them
    int model_words;
    int model_credits;

    always_ff @(posedge CLK_100MHz) begin
        if (!rst_n || clear) begin
            model_words   <= 0;
            model_credits <= CREDIT_INIT;
        end else begin
            model_words   <= model_words + ((word_push && model_words < FIFO_DEPTH) ? 1 : 0)
                             - (word_valid ? 1 : 0);
            model_credits <= model_credits + (credit_return ? 1 : 0) - (word_valid ? 1 : 0);
        end
    end

    // Consumer never hands back more than it got
    credit_bound: assert property (
        @(posedge CLK_100MHz) disable iff (!rst_n)
        credits <= credit_t'(CREDIT_INIT)
    ) else $error("credit count %0d above the initial grant", credits);

    valid_needs_credit: assert property (
        @(posedge CLK_100MHz) disable iff (!rst_n)
        word_valid |-> (model_credits > 0) && (model_words > 0)
    ) else $error("word_valid with no credit or an empty buffer");

    overflow_sticky: assert property (
        @(posedge CLK_100MHz) disable iff (!rst_n)
        $fell(overflow) |-> $past(!rst_n || clear)
    ) else $error("overflow dropped without reset or clear");

endmodule

bind rx_fifo uart_rx_asserts i_uart_rx_asserts (
    .CLK_100MHz    (CLK_100MHz),
    .rst_n         (rst_n),
    .clear         (clear),
    .word_push     (word_push),
    .credit_return (credit_return),
    .credits       (credits),
    .word_valid    (word_valid),
    .overflow      (overflow)
);

//--- uart_rx_pkg.sv
// UART receive definitions
package uart_rx_pkg;

    // Line timing
    localparam int CLK_FREQ  = 100_000_000;         // System clock in Hz
    localparam int BAUD_RATE = 115_200;

    // Clock cycles per bit, 868 at 100 MHz
    localparam int BIT_PERIOD  = CLK_FREQ / BAUD_RATE;
    localparam int HALF_PERIOD = (BIT_PERIOD - 1) / 2;  // Start edge to mid-bit, 433

    // Buffer and flow control
    localparam int FIFO_DEPTH  = 8;                 // Words, power of two
    localparam int CREDIT_INIT = 4;                 // Credits granted after reset or clear

    // Receive word layout
    //   [7:0]  data byte
    //   [14:8] zero
    //   [15]   framing error
    typedef logic [15:0] rx_word_t;
    typedef logic [7:0]  rx_byte_t;

    typedef logic [9:0] timer_t;                    // Holds BIT_PERIOD
    typedef logic [3:0] credit_t;

    // Frame state machine
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

endpackage

//--- uart_rx_top.sv
// UART receive subsystem top
`timescale 1ns/1ps

module uart_rx_top (
    input  logic                  CLK_100MHz,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  rx,
    input  logic                  credit_return,
    output uart_rx_pkg::rx_word_t word,
    output logic                  word_valid,
    output logic                  overflow
);
    import uart_rx_pkg::*;

    logic     rx_bit;                       // Synchronized line
    logic     timer_load;
    logic     timer_half;
    logic     timer_done;
    logic     shift_en;
    logic     word_push;
    logic     frame_err;
    rx_word_t rx_word;

    baud_timer i_baud_timer (
        .CLK_100MHz (CLK_100MHz),
        .rst_n      (rst_n),
        .clear      (clear),
        .timer_load (timer_load),
        .timer_half (timer_half),
        .timer_done (timer_done)
    );

    rx_fsm i_rx_fsm (
        .CLK_100MHz (CLK_100MHz),
        .rst_n      (rst_n),
        .clear      (clear),
        .rx_bit     (rx_bit),
        .timer_done (timer_done),
        .timer_load (timer_load),
        .timer_half (timer_half),
        .shift_en   (shift_en),
        .word_push  (word_push),
        .frame_err  (frame_err)
    );

    rx_shift i_rx_shift (
        .CLK_100MHz (CLK_100MHz),
        .rst_n      (rst_n),
        .clear      (clear),
        .rx         (rx),
        .shift_en   (shift_en),
        .frame_err  (frame_err),
        .rx_bit     (rx_bit),
        .rx_word    (rx_word)
    );

    // Buffer and credit control toward the consumer
    rx_fifo i_rx_fifo (
        .CLK_100MHz    (CLK_100MHz),
        .rst_n         (rst_n),
        .clear         (clear),
        .word_push     (word_push),
        .rx_word       (rx_word),
        .credit_return (credit_return),
        .word          (word),
        .word_valid    (word_valid),
        .overflow      (overflow)
    );

endmodule

//--- vlog.f
uart_rx_pkg.sv
baud_timer.sv
rx_fsm.sv
rx_shift.sv
rx_fifo.sv
uart_rx_top.sv
uart_rx_asserts.sv
tb_uart_rx.sv
